// ==== design/sensorPkg.sv ====
package sensorPkg;

	//==============================
	// wheel encoders
	//==============================

	localparam int numWheelChannels = 4; // propulsion L/R, odometry L/R
	localparam int speedWidth = 16;      // speed value and edge counter

	// one measurement window in CLOCK_50 cycles
	// board build used 500000 (10 ms), cut down here so a window simulates quickly
	localparam int speedWindowCycles = 1000;
	localparam int windowWidth = $clog2(speedWindowCycles);

	// mirrored mounting on right propulsion (bit 1) and left odometry (bit 2)
	localparam logic [numWheelChannels-1:0] directionInvert = 4'b0110;

	//==============================
	// laser tower
	//==============================

	localparam int angleWidth = 16; // tower angle and beacon positions

	// beam dropouts up to this many tower ticks merge into one reception
	localparam int glitchToleranceTicks = 20;
	localparam int glitchWidth = $clog2(glitchToleranceTicks + 1);

	typedef enum logic [1:0] {
		idle,      // no beam
		receiving, // beam present
		dropout    // beam lost, waiting to see if it comes back
	} beaconState;

endpackage

// ==== design/registerMapPkg.sv ====
package registerMapPkg;

	localparam int regWidth = 16;

	// host read addresses, 7 is unmapped and reads zero
	typedef enum logic [2:0] {
		regStatus      = 3'd0,
		regSpeed0      = 3'd1,
		regSpeed1      = 3'd2,
		regSpeed2      = 3'd3,
		regSpeed3      = 3'd4,
		regBeaconStart = 3'd5,
		regBeaconEnd   = 3'd6
	} regAddress;

	//==============================
	// status word layout
	//==============================

	localparam int statusIdBit = 0;
	localparam int statusDirLsb = 1;    // four direction bits, 1..4
	localparam int statusSwitchLsb = 5; // micro-switches, 5..9
	localparam int statusStartBit = 10;
	localparam int statusTurnBit = 11;
	// bits 12..15 stay zero

	localparam int numMicroSwitches = 5;

endpackage

// ==== design/wheelSpeedMeter.sv ====
`timescale 1ns/1ps

module wheelSpeedMeter
	import sensorPkg::*;
(
	input  logic                        CLOCK_50,
	input  logic                        reset,
	input  logic [numWheelChannels-1:0] encoderA,
	input  logic [numWheelChannels-1:0] encoderB,
	output logic [speedWidth-1:0]       wheelSpeed [numWheelChannels],
	output logic [numWheelChannels-1:0] wheelDirection,
	output logic                        speedUpdate
);

	// all eight encoder lines side by side, A channels low, B channels high
	logic [2*numWheelChannels-1:0] lineMeta;
	logic [2*numWheelChannels-1:0] lineSync;
	logic [2*numWheelChannels-1:0] linePrev;
	logic [2*numWheelChannels-1:0] lineRise;

	logic [windowWidth-1:0] windowCount;
	logic windowLast;

	logic [speedWidth-1:0] edgeCount [2*numWheelChannels];

	// (A + B) / 2 without losing the carry
	function automatic logic [speedWidth-1:0] averageEdges(
		input logic [speedWidth-1:0] countA,
		input logic [speedWidth-1:0] countB
	);
		logic [speedWidth:0] edgeSum;
		edgeSum = {1'b0, countA} + {1'b0, countB};
		return edgeSum[speedWidth:1];
	endfunction

	//==============================
	// input synchronizers
	//==============================

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			lineMeta <= '0;
			lineSync <= '0;
			linePrev <= '0;
		end else begin
			lineMeta <= {encoderB, encoderA};
			lineSync <= lineMeta;
			linePrev <= lineSync; // edge detect stage
		end
	end

	assign lineRise = lineSync & ~linePrev;

	//==============================
	// window and counters
	//==============================

	assign windowLast = (windowCount == windowWidth'(speedWindowCycles - 1));

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			windowCount <= '0;
			speedUpdate <= 1'b0;
		end else begin
			speedUpdate <= windowLast; // one cycle after the latch
			if (windowLast)
				windowCount <= '0;
			else
				windowCount <= windowCount + 1'b1;
		end
	end

	// counters clear while speedUpdate is high, i.e. right after the latch
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 2*numWheelChannels; i++)
				edgeCount[i] <= '0;
		end else begin
			for (int i = 0; i < 2*numWheelChannels; i++) begin
				if (speedUpdate)
					edgeCount[i] <= '0;
				else if (lineRise[i] && edgeCount[i] != '1)
					edgeCount[i] <= edgeCount[i] + 1'b1; // saturates at all ones
			end
		end
	end

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			for (int ch = 0; ch < numWheelChannels; ch++)
				wheelSpeed[ch] <= '0;
		end else if (windowLast) begin
			for (int ch = 0; ch < numWheelChannels; ch++)
				wheelSpeed[ch] <= averageEdges(edgeCount[ch], edgeCount[ch+numWheelChannels]);
		end
	end

	// quadrature direction, B level sampled at A rise
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			wheelDirection <= '0;
		end else begin
			for (int ch = 0; ch < numWheelChannels; ch++) begin
				if (lineRise[ch])
					wheelDirection[ch] <= lineSync[ch+numWheelChannels] ^ directionInvert[ch];
			end
		end
	end

	updateSinglePulse: assert property (@(posedge CLOCK_50) disable iff (reset)
		speedUpdate |=> !speedUpdate);

	windowInRange: assert property (@(posedge CLOCK_50) disable iff (reset)
		windowCount < speedWindowCycles);

endmodule

// ==== design/beaconDetector.sv ====
`timescale 1ns/1ps

module beaconDetector
	import sensorPkg::*;
(
	input  logic                  CLOCK_50,
	input  logic                  reset,
	input  logic                  towerEncoder,
	input  logic                  towerSync,
	input  logic                  laserSign,
	output logic [angleWidth-1:0] beaconStart,
	output logic [angleWidth-1:0] beaconEnd,
	output logic                  towerTurn,
	output logic                  beaconUpdate
);

	// bit 0 tower encoder, bit 1 tower sync, bit 2 laser
	logic [2:0] lineMeta;
	logic [2:0] lineSync;
	logic [1:0] linePrev; // edge detect for encoder and sync only

	logic tickRise;
	logic syncRise;
	logic laserOn;

	logic [angleWidth-1:0] towerAngle;
	logic [angleWidth-1:0] startCandidate;
	logic [angleWidth-1:0] endCandidate;
	logic [glitchWidth-1:0] dropTicks; // tower ticks spent in dropout

	beaconState state;

	//==============================
	// synchronizers
	//==============================

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			lineMeta <= '0;
			lineSync <= '0;
			linePrev <= '0;
		end else begin
			lineMeta <= {laserSign, towerSync, towerEncoder};
			lineSync <= lineMeta;
			linePrev <= lineSync[1:0];
		end
	end

	assign tickRise = lineSync[0] & ~linePrev[0];
	assign syncRise = lineSync[1] & ~linePrev[1];
	assign laserOn = lineSync[2];

	//==============================
	// tower angle and turn
	//==============================

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			towerAngle <= '0;
			towerTurn <= 1'b0;
		end else if (syncRise) begin
			towerAngle <= '0; // index mark wins over a tick
			towerTurn <= ~towerTurn;
		end else if (tickRise) begin
			towerAngle <= towerAngle + 1'b1;
		end
	end

	//==============================
	// reception FSM
	//==============================

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			state <= idle;
			dropTicks <= '0;
			beaconStart <= '0;
			beaconEnd <= '0;
			beaconUpdate <= 1'b0;
		end else begin
			beaconUpdate <= 1'b0;
			case (state)
				idle: begin
					if (laserOn)
						state <= receiving;
				end
				receiving: begin
					if (!laserOn) begin
						state <= dropout;
						dropTicks <= '0;
					end
				end
				dropout: begin
					if (laserOn) begin
						state <= receiving; // short gap belongs to the same beacon
					end else if (dropTicks == glitchWidth'(glitchToleranceTicks)) begin
						beaconStart <= startCandidate;
						beaconEnd <= endCandidate;
						beaconUpdate <= 1'b1;
						state <= idle;
					end else if (tickRise) begin
						dropTicks <= dropTicks + 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// candidate angles held until published from dropout
	always_ff @(posedge CLOCK_50) begin
		if (state == idle && laserOn)
			startCandidate <= towerAngle;
		if (state == receiving && !laserOn)
			endCandidate <= towerAngle; // overwritten if the beam returns
	end

	stateLegal: assert property (@(posedge CLOCK_50) disable iff (reset)
		state inside {idle, receiving, dropout});

	updateFromDropout: assert property (@(posedge CLOCK_50) disable iff (reset)
		beaconUpdate |-> $past(state) == dropout);

endmodule

// ==== design/sensorRegisterBank.sv ====
`timescale 1ns/1ps

module sensorRegisterBank
	import sensorPkg::*;
	import registerMapPkg::*;
(
	input  logic                        CLOCK_50,
	input  logic                        reset,
	input  logic [speedWidth-1:0]       wheelSpeed [numWheelChannels],
	input  logic [numWheelChannels-1:0] wheelDirection,
	input  logic [angleWidth-1:0]       beaconStart,
	input  logic [angleWidth-1:0]       beaconEnd,
	input  logic                        towerTurn,
	input  logic [numMicroSwitches-1:0] microSwitches,
	input  logic                        startSwitch,
	input  logic                        boardId,
	input  registerMapPkg::regAddress   regAddress,
	output logic [regWidth-1:0]         regData
);

	// {id, start, switches}
	logic [numMicroSwitches+1:0] levelMeta;
	logic [numMicroSwitches+1:0] levelSync;

	logic [regWidth-1:0] statusWord;

	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			levelMeta <= '0;
			levelSync <= '0;
		end else begin
			levelMeta <= {boardId, startSwitch, microSwitches};
			levelSync <= levelMeta;
		end
	end

	//==============================
	// status word
	//==============================

	always_comb begin
		statusWord = '0; // unused upper bits
		statusWord[statusIdBit] = levelSync[numMicroSwitches+1];
		statusWord[statusDirLsb +: numWheelChannels] = wheelDirection;
		statusWord[statusSwitchLsb +: numMicroSwitches] = levelSync[numMicroSwitches-1:0];
		statusWord[statusStartBit] = levelSync[numMicroSwitches];
		statusWord[statusTurnBit] = towerTurn;
	end

	// read port, one cycle latency
	always_ff @(posedge CLOCK_50 or posedge reset) begin
		if (reset) begin
			regData <= '0;
		end else begin
			case (regAddress)
				regStatus:      regData <= statusWord;
				regSpeed0:      regData <= wheelSpeed[0];
				regSpeed1:      regData <= wheelSpeed[1];
				regSpeed2:      regData <= wheelSpeed[2];
				regSpeed3:      regData <= wheelSpeed[3];
				regBeaconStart: regData <= beaconStart;
				regBeaconEnd:   regData <= beaconEnd;
				default:        regData <= '0;
			endcase
		end
	end

	unmappedReadsZero: assert property (@(posedge CLOCK_50) disable iff (reset)
		(regAddress == 3'd7) |=> (regData == '0));

endmodule

// ==== design/robotSensorHub.sv ====
`timescale 1ns/1ps

module robotSensorHub
	import sensorPkg::*;
	import registerMapPkg::*;
(
	input  logic                        CLOCK_50,
	input  logic                        reset,
	input  logic [numWheelChannels-1:0] encoderA,
	input  logic [numWheelChannels-1:0] encoderB,
	input  logic                        towerEncoder,
	input  logic                        towerSync,
	input  logic                        laserSign,
	input  logic [numMicroSwitches-1:0] microSwitches,
	input  logic                        startSwitch,
	input  logic                        boardId,
	input  registerMapPkg::regAddress   regAddress,
	output logic [regWidth-1:0]         regData,
	output logic                        speedUpdate,
	output logic                        beaconUpdate
);

	logic [speedWidth-1:0] wheelSpeed [numWheelChannels];
	logic [numWheelChannels-1:0] wheelDirection;
	logic [angleWidth-1:0] beaconStart;
	logic [angleWidth-1:0] beaconEnd;
	logic towerTurn;

	wheelSpeedMeter speedMeter (
		.CLOCK_50       (CLOCK_50),
		.reset          (reset),
		.encoderA       (encoderA),
		.encoderB       (encoderB),
		.wheelSpeed     (wheelSpeed),
		.wheelDirection (wheelDirection),
		.speedUpdate    (speedUpdate)
	);

	beaconDetector beacon (
		.CLOCK_50     (CLOCK_50),
		.reset        (reset),
		.towerEncoder (towerEncoder),
		.towerSync    (towerSync),
		.laserSign    (laserSign),
		.beaconStart  (beaconStart),
		.beaconEnd    (beaconEnd),
		.towerTurn    (towerTurn),
		.beaconUpdate (beaconUpdate)
	);

	sensorRegisterBank registers (
		.CLOCK_50, .reset, .wheelSpeed, .wheelDirection, .beaconStart, .beaconEnd,
		.towerTurn, .microSwitches, .startSwitch, .boardId, .regAddress, .regData
	);

endmodule

// ==== testbench/robotSensorHub_tb.sv ====
`timescale 1ns/1ps

module robotSensorHub_tb
	import sensorPkg::*;
	import registerMapPkg::*;
();

	localparam int driveDelay = 5; // ns after the rising edge
	localparam int holdCycles = 3; // long enough for the two-flop synchronizers

	logic CLOCK_50;
	logic reset;
	logic [numWheelChannels-1:0] encoderA;
	logic [numWheelChannels-1:0] encoderB;
	logic towerEncoder;
	logic towerSync;
	logic laserSign;
	logic [numMicroSwitches-1:0] microSwitches;
	logic startSwitch;
	logic boardId;
	registerMapPkg::regAddress readAddress;
	logic [regWidth-1:0] regData;
	logic speedUpdate;
	logic beaconUpdate;

	logic [numWheelChannels-1:0] expDir; // model of the direction bits
	logic expTurn;

	// reads waiting for the compare process
	string nameQ[$];
	logic [regWidth-1:0] gotQ[$];
	logic [regWidth-1:0] expQ[$];
	string checkName;
	logic [regWidth-1:0] gotValue;
	logic [regWidth-1:0] expValue;

	robotSensorHub DUT (
		.CLOCK_50, .reset, .encoderA, .encoderB, .towerEncoder, .towerSync, .laserSign,
		.microSwitches, .startSwitch, .boardId, .regAddress(readAddress), .regData,
		.speedUpdate, .beaconUpdate
	);

	initial CLOCK_50 = 1'b0;
	always #20 CLOCK_50 = ~CLOCK_50;

	//==============================
	// reference model
	//==============================

	function automatic logic [regWidth-1:0] expectedSpeed(input int aPulses, input int bPulses);
		return regWidth'((aPulses + bPulses) / 2); // rounds down
	endfunction

	function automatic logic expectedDirection(input logic bAtRise, input int ch);
		return bAtRise ^ directionInvert[ch];
	endfunction

	// receptions seen for one or two laser pulses split by a gap of tower ticks
	function automatic int receptionCount(input int gapTicks, input int secondLen);
		if (secondLen == 0)
			return 1;
		return (gapTicks < glitchToleranceTicks) ? 1 : 2;
	endfunction

	function automatic logic [regWidth-1:0] expectedStatus(input logic id, input logic start,
			input logic [numMicroSwitches-1:0] switches, input logic [numWheelChannels-1:0] dir,
			input logic turn);
		logic [regWidth-1:0] word;
		word = '0;
		word[statusIdBit] = id;
		word[statusDirLsb +: numWheelChannels] = dir;
		word[statusSwitchLsb +: numMicroSwitches] = switches;
		word[statusStartBit] = start;
		word[statusTurnBit] = turn;
		return word;
	endfunction

	// compares queued samples between the read samples
	always @(negedge CLOCK_50) begin
		while (gotQ.size() > 0) begin
			checkName = nameQ.pop_front();
			gotValue = gotQ.pop_front();
			expValue = expQ.pop_front();
			assert (gotValue === expValue) else begin
				$display("CHECK FAILED %s got 0x%04h expected 0x%04h", checkName, gotValue,
					expValue);
				$display("Testbench failed");
				$fatal(1, "register read did not match the model");
			end
		end
	end

	//==============================
	// bus and pin tasks
	//==============================

	task automatic nextCycle();
		@(posedge CLOCK_50);
		#driveDelay;
	endtask

	task automatic queueCheck(input string name, input logic [regWidth-1:0] got,
			input logic [regWidth-1:0] expected);
		nameQ.push_back(name);
		gotQ.push_back(got);
		expQ.push_back(expected);
	endtask

	task automatic readCheck(input registerMapPkg::regAddress addr, input string name,
			input logic [regWidth-1:0] expected);
		readAddress = addr;
		nextCycle(); // fixed latency of one
		queueCheck(name, regData, expected);
	endtask

	task automatic checkStatus();
		readCheck(regStatus, "regStatus",
			expectedStatus(boardId, startSwitch, microSwitches, expDir, expTurn));
	endtask

	task automatic waitSpeedUpdate();
		logic seen;
		seen = 1'b0;
		for (int n = 0; n < 2*speedWindowCycles && !seen; n++) begin
			nextCycle();
			seen = speedUpdate;
		end
		if (!seen) begin
			$display("speedUpdate never arrived within two windows");
			$display("Testbench failed");
			$fatal(1, "timeout on speedUpdate");
		end
		nextCycle();
		queueCheck("speedUpdate", regWidth'(speedUpdate), '0); // one-cycle pulse
	endtask

	task automatic waitBeaconUpdate();
		logic seen;
		seen = 1'b0;
		for (int n = 0; n < 3000 && !seen; n++) begin
			nextCycle();
			seen = beaconUpdate;
		end
		if (!seen) begin
			$display("beaconUpdate never arrived after the laser pulse");
			$display("Testbench failed");
			$fatal(1, "timeout on beaconUpdate");
		end
		nextCycle();
		queueCheck("beaconUpdate", regWidth'(beaconUpdate), '0); // one-cycle pulse
	endtask

	task automatic towerTicks(input int count);
		repeat (count) begin
			towerEncoder = 1'b1;
			repeat (holdCycles) nextCycle();
			towerEncoder = 1'b0;
			repeat (holdCycles) nextCycle();
		end
	endtask

	task automatic setLaser(input logic level);
		laserSign = level;
		repeat (holdCycles + 1) nextCycle(); // settle before the next tick
	endtask

	task automatic towerSyncPulse();
		towerSync = 1'b1;
		repeat (holdCycles) nextCycle();
		towerSync = 1'b0;
		repeat (holdCycles + 1) nextCycle();
	endtask

	//==============================
	// scenarios
	//==============================

	task automatic runSpeedRound();
		int aCount [numWheelChannels];
		int aRises [numWheelChannels];
		int bRises [numWheelChannels];
		logic [numWheelChannels-1:0] stepB;
		int maxSteps;
		maxSteps = 0;
		stepB = '0;
		for (int ch = 0; ch < numWheelChannels; ch++) begin
			aCount[ch] = $urandom_range(1, 40);
			aRises[ch] = 0;
			bRises[ch] = 0;
			if (aCount[ch] > maxSteps)
				maxSteps = aCount[ch];
		end
		waitSpeedUpdate();      // start of a fresh window
		repeat (250) nextCycle(); // into the middle half
		for (int k = 0; k < maxSteps; k++) begin
			for (int ch = 0; ch < numWheelChannels; ch++) begin
				if (k < aCount[ch]) begin
					stepB[ch] = 1'($urandom_range(0, 1));
					encoderB[ch] = stepB[ch];
					if (stepB[ch])
						bRises[ch]++;
				end
			end
			repeat (holdCycles) nextCycle();
			for (int ch = 0; ch < numWheelChannels; ch++) begin
				if (k < aCount[ch]) begin
					encoderA[ch] = 1'b1;
					aRises[ch]++;
					expDir[ch] = expectedDirection(stepB[ch], ch);
				end
			end
			repeat (holdCycles) nextCycle();
			encoderA = '0;
			encoderB = '0;
			repeat (holdCycles) nextCycle();
		end
		waitSpeedUpdate();
		for (int ch = 0; ch < numWheelChannels; ch++)
			readCheck(registerMapPkg::regAddress'(ch + 1), $sformatf("regSpeed%0d", ch),
				expectedSpeed(aRises[ch], bRises[ch]));
		checkStatus();
	endtask

	// secondLen of zero means one clean pulse
	task automatic runBeacon(input int firstLen, input int gapTicks, input int secondLen);
		int firstStart;
		int firstEnd;
		int secondStart;
		int secondEnd;
		int receptions;
		int expStart [2];
		int expEnd [2];
		firstStart = $urandom_range(3, 20);
		firstEnd = firstStart + firstLen;
		secondStart = firstEnd + gapTicks;
		secondEnd = secondStart + secondLen;
		receptions = receptionCount(gapTicks, secondLen);
		expStart[0] = firstStart;
		expEnd[0] = (secondLen > 0 && receptions == 1) ? secondEnd : firstEnd;
		expStart[1] = secondStart;
		expEnd[1] = secondEnd;
		towerSyncPulse(); // angle back to zero
		expTurn = ~expTurn;
		checkStatus();
		fork
			begin
				towerTicks(firstStart);
				setLaser(1'b1);
				towerTicks(firstLen);
				setLaser(1'b0);
				if (secondLen > 0) begin
					towerTicks(gapTicks);
					setLaser(1'b1);
					towerTicks(secondLen);
					setLaser(1'b0);
				end
				towerTicks(glitchToleranceTicks + 8); // let the dropout expire
			end
			begin
				for (int r = 0; r < receptions; r++) begin
					waitBeaconUpdate();
					readCheck(regBeaconStart, "regBeaconStart", regWidth'(expStart[r]));
					readCheck(regBeaconEnd, "regBeaconEnd", regWidth'(expEnd[r]));
				end
			end
		join
	endtask

	//==============================
	// main sequence
	//==============================

	initial begin
		void'($urandom(97));
		reset = 1'b1;
		encoderA = '0;
		encoderB = '0;
		towerEncoder = 1'b0;
		towerSync = 1'b0;
		laserSign = 1'b0;
		microSwitches = '0;
		startSwitch = 1'b0;
		boardId = 1'b0;
		readAddress = regStatus;
		expDir = '0;
		expTurn = 1'b0;
		repeat (2) nextCycle();
		reset = 1'b0;

		// update pulses idle after reset
		queueCheck("speedUpdate", regWidth'(speedUpdate), '0);
		queueCheck("beaconUpdate", regWidth'(beaconUpdate), '0);

		// everything reads zero before the first window ends
		readCheck(regStatus, "regStatus", '0);
		for (int a = 1; a <= 6; a++)
			readCheck(registerMapPkg::regAddress'(a), $sformatf("address %0d", a), '0);
		readCheck(registerMapPkg::regAddress'(3'd7), "address 7", '0);

		repeat (3) runSpeedRound();

		// clean pulses each after its own index mark
		runBeacon($urandom_range(3, 15), 0, 0);
		runBeacon($urandom_range(3, 15), 0, 0);

		// short gap merges and long gap splits
		runBeacon($urandom_range(3, 10), $urandom_range(1, glitchToleranceTicks - 2),
			$urandom_range(3, 10));
		runBeacon($urandom_range(3, 10),
			$urandom_range(glitchToleranceTicks + 2, glitchToleranceTicks + 15),
			$urandom_range(3, 10));

		repeat (8) begin
			microSwitches = numMicroSwitches'($urandom_range(0, 31));
			startSwitch = 1'($urandom_range(0, 1));
			boardId = 1'($urandom_range(0, 1));
			repeat (holdCycles + 1) nextCycle();
			checkStatus();
			readCheck(registerMapPkg::regAddress'(3'd7), "address 7", '0);
		end

		@(negedge CLOCK_50);
		#1; // last queued reads are compared by now
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== robotSensorHub.f ====
design/sensorPkg.sv
design/registerMapPkg.sv
design/wheelSpeedMeter.sv
design/beaconDetector.sv
design/sensorRegisterBank.sv
design/robotSensorHub.sv
testbench/robotSensorHub_tb.sv

// ==== Makefile ====
# Verilator build and run of robotSensorHub_tb

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module robotSensorHub_tb \
		-f robotSensorHub.f -Mdir obj_dir -o robotSensorHub_sim
	./obj_dir/robotSensorHub_sim

clean:
	rm -rf obj_dir
